// File: Bender.yml
package:
  name: axi_lite_sys

sources:
  - rtl/axi_conv_pkg.sv
  - rtl/axi_lite_if.sv
  - rtl/axi_write_converter.sv
  - rtl/axi_read_converter.sv
  - rtl/axi_lite_regfile.sv
  - rtl/axi_lite_sys.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/axi_lite_sys_properties.sv
      - tests/tb_axi_lite_sys.sv

// File: axi_lite_sys.f
rtl/axi_conv_pkg.sv
rtl/axi_lite_if.sv
rtl/axi_write_converter.sv
rtl/axi_read_converter.sv
rtl/axi_lite_regfile.sv
rtl/axi_lite_sys.sv
tests/tb_clock_gen.sv
tests/axi_lite_sys_properties.sv
tests/tb_axi_lite_sys.sv

// File: rtl/axi_conv_pkg.sv
// ##############################
// AXI conversion shared types
// ##############################

package axi_conv_pkg;

  // Bus widths shared by the full AXI4 port and the Lite bus
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Only the full AXI4 side carries IDs and burst lengths
  localparam int ID_WIDTH  = 8;
  localparam int LEN_WIDTH = 8;

  // Register file geometry
  localparam int REG_COUNT     = 16;
  localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);

  // Byte span of the register file, anything at or above is out of range
  localparam logic [ADDR_WIDTH-1:0] REG_SPAN = ADDR_WIDTH'(REG_COUNT * STRB_WIDTH);

  // Response codes as encoded on BRESP and RRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

endpackage

// File: rtl/axi_lite_if.sv
// ##############################
// AXI4-Lite bus
// ##############################

interface axi_lite_if;
  import axi_conv_pkg::*;

  logic [ADDR_WIDTH-1:0] aw_addr;
  logic                  aw_valid;
  logic                  aw_ready;
  logic [DATA_WIDTH-1:0] w_data;
  logic [STRB_WIDTH-1:0] w_strb;
  logic                  w_valid;
  logic                  w_ready;
  resp_t                 b_resp;
  logic                  b_valid;
  logic                  b_ready;
  logic [ADDR_WIDTH-1:0] ar_addr;
  logic                  ar_valid;
  logic                  ar_ready;
  logic [DATA_WIDTH-1:0] r_data;
  resp_t                 r_resp;
  logic                  r_valid;
  logic                  r_ready;

  // The converters share the master side, each drives only its own channels
  modport master (
    output aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready, ar_addr, ar_valid, r_ready,
    input  aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
  );

  modport slave (
    input  aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready, ar_addr, ar_valid, r_ready,
    output aw_ready, w_ready, b_resp, b_valid, ar_ready, r_data, r_resp, r_valid
  );

endinterface

// File: rtl/axi_lite_regfile.sv
// ##############################
// AXI4-Lite register file
// ##############################

module axi_lite_regfile (
  input  logic      clk,
  input  logic      reset,
  axi_lite_if.slave bus
);
  import axi_conv_pkg::*;

  logic [DATA_WIDTH-1:0]    regs [REG_COUNT];
  logic                     wr_fire;
  logic                     rd_fire;
  logic [REG_IDX_WIDTH-1:0] wr_idx;
  logic [REG_IDX_WIDTH-1:0] rd_idx;
  logic                     wr_in_range;
  logic                     rd_in_range;

  // Address and data are taken in the same cycle, and only with no B pending
  assign wr_fire      = bus.aw_valid && bus.w_valid && !bus.b_valid;
  assign bus.aw_ready = wr_fire;
  assign bus.w_ready  = wr_fire;

  // One read in flight, a new address waits for the held R to drain
  assign bus.ar_ready = !bus.r_valid;
  assign rd_fire      = bus.ar_valid && bus.ar_ready;

  // Word index from the low address bits above the byte offset
  assign wr_idx      = bus.aw_addr[REG_IDX_WIDTH+1:2];
  assign rd_idx      = bus.ar_addr[REG_IDX_WIDTH+1:2];
  assign wr_in_range = (bus.aw_addr < REG_SPAN);
  assign rd_in_range = (bus.ar_addr < REG_SPAN);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_fire && wr_in_range) begin
      // Only the strobed bytes change, the rest keep their value
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (bus.w_strb[b]) regs[wr_idx][8*b +: 8] <= bus.w_data[8*b +: 8];
      end
    end
  end

  // Write response flag
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.b_valid <= 1'b0;
    end else if (wr_fire) begin
      bus.b_valid <= 1'b1;
    end else if (bus.b_ready) begin
      bus.b_valid <= 1'b0;
    end
  end

  // Read response flag
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.r_valid <= 1'b0;
    end else if (rd_fire) begin
      bus.r_valid <= 1'b1;
    end else if (bus.r_ready) begin
      bus.r_valid <= 1'b0;
    end
  end

  // Response payloads, out of range reads return zero
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bus.b_resp <= wr_in_range ? OKAY : SLVERR;
    end
    if (rd_fire) begin
      bus.r_data <= rd_in_range ? regs[rd_idx] : '0;
      bus.r_resp <= rd_in_range ? OKAY : SLVERR;
    end
  end

endmodule

// File: rtl/axi_lite_sys.sv
// ##############################
// AXI4 to Lite subsystem
// ##############################

module axi_lite_sys (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [axi_conv_pkg::ID_WIDTH-1:0]   awid,
  input  logic [axi_conv_pkg::ADDR_WIDTH-1:0] awaddr,
  input  logic [axi_conv_pkg::LEN_WIDTH-1:0]  awlen,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [axi_conv_pkg::DATA_WIDTH-1:0] wdata,
  input  logic [axi_conv_pkg::STRB_WIDTH-1:0] wstrb,
  input  logic                                wlast,
  input  logic                                wvalid,
  output logic                                wready,
  output logic [axi_conv_pkg::ID_WIDTH-1:0]   bid,
  output axi_conv_pkg::resp_t                 bresp,
  output logic                                bvalid,
  input  logic                                bready,
  input  logic [axi_conv_pkg::ID_WIDTH-1:0]   arid,
  input  logic [axi_conv_pkg::ADDR_WIDTH-1:0] araddr,
  input  logic [axi_conv_pkg::LEN_WIDTH-1:0]  arlen,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [axi_conv_pkg::ID_WIDTH-1:0]   rid,
  output logic [axi_conv_pkg::DATA_WIDTH-1:0] rdata,
  output axi_conv_pkg::resp_t                 rresp,
  output logic                                rlast,
  output logic                                rvalid,
  input  logic                                rready
);

  // Single Lite bus, the write and read converters own disjoint channels
  axi_lite_if lite_bus ();

  axi_write_converter u_write_converter (
    .clk     (clk),
    .reset   (reset),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wvalid  (wvalid),
    .wready  (wready),
    .bid     (bid),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .lite    (lite_bus.master)
  );

  axi_read_converter u_read_converter (
    .clk     (clk),
    .reset   (reset),
    .arid    (arid),
    .araddr  (araddr),
    .arlen   (arlen),
    .arvalid (arvalid),
    .arready (arready),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .rvalid  (rvalid),
    .rready  (rready),
    .lite    (lite_bus.master)
  );

  axi_lite_regfile u_regfile (
    .clk   (clk),
    .reset (reset),
    .bus   (lite_bus.slave)
  );

endmodule

// File: rtl/axi_read_converter.sv
// ##############################
// AXI4 to Lite read converter
// ##############################

module axi_read_converter (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [axi_conv_pkg::ID_WIDTH-1:0]   arid,
  input  logic [axi_conv_pkg::ADDR_WIDTH-1:0] araddr,
  input  logic [axi_conv_pkg::LEN_WIDTH-1:0]  arlen,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [axi_conv_pkg::ID_WIDTH-1:0]   rid,
  output logic [axi_conv_pkg::DATA_WIDTH-1:0] rdata,
  output axi_conv_pkg::resp_t                 rresp,
  output logic                                rlast,
  output logic                                rvalid,
  input  logic                                rready,
  axi_lite_if.master                          lite
);
  import axi_conv_pkg::*;

  // ST_BEAT serves both the forwarded single beat and the burst error beats
  enum logic [1:0] {ST_IDLE, ST_LITE, ST_BEAT} state;

  logic [ID_WIDTH-1:0]   id_q;
  logic [LEN_WIDTH-1:0]  cnt_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic                  ar_pend;
  logic [DATA_WIDTH-1:0] data_q;
  resp_t                 resp_q;

  // No address is taken while reset is held
  assign arready = (state == ST_IDLE) && !reset;
  assign rvalid  = (state == ST_BEAT);
  assign rid     = id_q;
  assign rdata   = data_q;
  assign rresp   = resp_q;
  // A single beat loads a zero count, so it is always the last
  assign rlast   = (cnt_q == '0);

  assign lite.ar_addr  = addr_q;
  assign lite.ar_valid = ar_pend;
  assign lite.r_ready  = (state == ST_LITE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      cnt_q   <= '0;
      ar_pend <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (arvalid) begin
            cnt_q   <= arlen;
            ar_pend <= (arlen == '0);
            state   <= (arlen == '0) ? ST_LITE : ST_BEAT;
          end
        end
        ST_LITE: begin
          if (lite.ar_valid && lite.ar_ready) ar_pend <= 1'b0;
          if (lite.r_valid) state <= ST_BEAT;
        end
        ST_BEAT: begin
          if (rready && cnt_q == '0) begin
            state <= ST_IDLE;
          end else if (rready) begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Burst beats carry zero data and SLVERR, single beats carry the Lite result
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      id_q   <= arid;
      addr_q <= araddr;
      data_q <= '0;
      resp_q <= SLVERR;
    end
    if (lite.r_valid && lite.r_ready) begin
      data_q <= lite.r_data;
      resp_q <= lite.r_resp;
    end
  end

endmodule

// File: rtl/axi_write_converter.sv
// ##############################
// AXI4 to Lite write converter
// ##############################

module axi_write_converter (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [axi_conv_pkg::ID_WIDTH-1:0]   awid,
  input  logic [axi_conv_pkg::ADDR_WIDTH-1:0] awaddr,
  input  logic [axi_conv_pkg::LEN_WIDTH-1:0]  awlen,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [axi_conv_pkg::DATA_WIDTH-1:0] wdata,
  input  logic [axi_conv_pkg::STRB_WIDTH-1:0] wstrb,
  input  logic                                wlast,
  input  logic                                wvalid,
  output logic                                wready,
  output logic [axi_conv_pkg::ID_WIDTH-1:0]   bid,
  output axi_conv_pkg::resp_t                 bresp,
  output logic                                bvalid,
  input  logic                                bready,
  axi_lite_if.master                          lite
);
  import axi_conv_pkg::*;

  // One transaction at a time: address, data, Lite exchange, then B
  enum logic [1:0] {ST_IDLE, ST_DATA, ST_LITE, ST_RESP} state;

  logic [ID_WIDTH-1:0]   id_q;
  logic                  burst_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic [STRB_WIDTH-1:0] strb_q;
  logic                  aw_pend;
  logic                  w_pend;
  resp_t                 resp_q;

  // Each channel is open in exactly one state
  // No address is taken while reset is held
  assign awready = (state == ST_IDLE) && !reset;
  assign wready  = (state == ST_DATA);
  assign bvalid  = (state == ST_RESP);
  assign bid     = id_q;
  assign bresp   = resp_q;

  // Lite AW and W are raised together and dropped independently on acceptance
  assign lite.aw_addr  = addr_q;
  assign lite.aw_valid = aw_pend;
  assign lite.w_data   = data_q;
  assign lite.w_strb   = strb_q;
  assign lite.w_valid  = w_pend;
  assign lite.b_ready  = (state == ST_LITE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      burst_q <= 1'b0;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (awvalid) begin
            // A nonzero length marks a burst, which is never forwarded
            burst_q <= (awlen != '0);
            state   <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (wvalid && !burst_q) begin
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
            state   <= ST_LITE;
          end else if (wvalid && wlast) begin
            // Burst beats are swallowed until the last one
            state <= ST_RESP;
          end
        end
        ST_LITE: begin
          if (lite.aw_valid && lite.aw_ready) aw_pend <= 1'b0;
          if (lite.w_valid && lite.w_ready) w_pend <= 1'b0;
          if (lite.b_valid) state <= ST_RESP;
        end
        ST_RESP: begin
          if (bready) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Transaction payload, captured on each handshake
  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      id_q   <= awid;
      addr_q <= awaddr;
    end
    if (wvalid && wready) begin
      data_q <= wdata;
      strb_q <= wstrb;
    end
    // The B response is either passed through from Lite or an error for a burst
    if (lite.b_valid && lite.b_ready) begin
      resp_q <= lite.b_resp;
    end else if (wvalid && wready && burst_q && wlast) begin
      resp_q <= SLVERR;
    end
  end

endmodule

// File: tests/axi_lite_sys_input.txt
# op id addr len wdata strb exp_rdata exp_resp, all hex after op (W or R)
# exp_resp is 0 OKAY, 1 EXOKAY, 2 SLVERR, 3 DECERR
R 01 00000008 00 00000000 0 00000000 0
W 11 00000008 00 a5a5a5a5 f 00000000 0
R 12 00000008 00 00000000 0 a5a5a5a5 0
W 13 00000008 00 11223344 5 00000000 0
R 14 00000008 00 00000000 0 a522a544 0
W 15 00000008 00 ffeeddcc a 00000000 0
R 16 00000008 00 00000000 0 ff22dd44 0
W 21 0000003c 00 deadbeef f 00000000 0
R 22 0000003c 00 00000000 0 deadbeef 0
W 31 00000040 00 12345678 f 00000000 2
R 32 00000040 00 00000000 0 00000000 2
R 33 00000000 00 00000000 0 00000000 0
W 41 00000004 03 cafef00d f 00000000 2
R 42 00000004 00 00000000 0 00000000 0
R 51 00000008 07 00000000 0 00000000 2
R 52 00000008 00 00000000 0 ff22dd44 0
W 61 00000010 00 01020304 3 00000000 0
W 62 00000014 00 0a0b0c0d c 00000000 0
R 63 00000010 00 00000000 0 00000304 0
R 64 00000014 00 00000000 0 0a0b0000 0
R 65 0000003c 01 00000000 0 00000000 2
R 66 0000003c 00 00000000 0 deadbeef 0

// File: tests/axi_lite_sys_properties.sv
// ##############################
// AXI4 port handshake checks
// ##############################

module axi_lite_sys_properties (
  input logic                                clk,
  input logic                                reset,
  input logic                                awready,
  input logic                                wready,
  input logic [axi_conv_pkg::ID_WIDTH-1:0]   bid,
  input axi_conv_pkg::resp_t                 bresp,
  input logic                                bvalid,
  input logic                                bready,
  input logic [axi_conv_pkg::ID_WIDTH-1:0]   rid,
  input logic [axi_conv_pkg::DATA_WIDTH-1:0] rdata,
  input axi_conv_pkg::resp_t                 rresp,
  input logic                                rlast,
  input logic                                rvalid,
  input logic                                rready
);
  timeunit 1ns;
  timeprecision 100ps;

  // A stalled B beat keeps its ID and response until bready
  b_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
    else $error("B beat changed while stalled");

  // A stalled R beat keeps its whole payload, rlast included
  r_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata)
                          && $stable(rresp) && $stable(rlast))
    else $error("R beat changed while stalled");

  // Neither write ready may rise on any cycle while reset is held
  ready_in_reset: assert property (@(posedge clk)
    reset |-> !$rose(awready) && !$rose(wready))
    else $error("Write ready rose during reset");

  // No response leaves the port while reset is held
  valid_in_reset: assert property (@(posedge clk)
    reset && $past(reset) |-> !bvalid && !rvalid)
    else $error("Response valid during reset");

endmodule

// File: tests/tb_axi_lite_sys.sv
// ##############################
// AXI4 to Lite subsystem bench
// ##############################

module tb_axi_lite_sys;
  timeunit 1ns;
  timeprecision 100ps;
  import axi_conv_pkg::*;

  localparam string VECTOR_FILE     = "tests/axi_lite_sys_input.txt";
  localparam int    MAX_TESTS       = 64;
  localparam int    RESET_CYCLES    = 16;
  localparam int    CYCLES_PER_TEST = 60;
  localparam int    CYCLES_PER_BEAT = 8;
  localparam int    DRIVE_DELAY     = 2;

  logic                  clk;
  logic                  reset;
  logic [ID_WIDTH-1:0]   awid;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic [LEN_WIDTH-1:0]  awlen;
  logic                  awvalid;
  logic                  awready;
  logic [DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0] wstrb;
  logic                  wlast;
  logic                  wvalid;
  logic                  wready;
  logic [ID_WIDTH-1:0]   bid;
  resp_t                 bresp;
  logic                  bvalid;
  logic                  bready;
  logic [ID_WIDTH-1:0]   arid;
  logic [ADDR_WIDTH-1:0] araddr;
  logic [LEN_WIDTH-1:0]  arlen;
  logic                  arvalid;
  logic                  arready;
  logic [ID_WIDTH-1:0]   rid;
  logic [DATA_WIDTH-1:0] rdata;
  resp_t                 rresp;
  logic                  rlast;
  logic                  rvalid;
  logic                  rready;

  // One entry per vector line
  logic [7:0]            vec_op   [MAX_TESTS];
  logic [ID_WIDTH-1:0]   vec_id   [MAX_TESTS];
  logic [ADDR_WIDTH-1:0] vec_addr [MAX_TESTS];
  logic [LEN_WIDTH-1:0]  vec_len  [MAX_TESTS];
  logic [DATA_WIDTH-1:0] vec_data [MAX_TESTS];
  logic [STRB_WIDTH-1:0] vec_strb [MAX_TESTS];
  logic [DATA_WIDTH-1:0] vec_exp  [MAX_TESTS];
  resp_t                 vec_resp [MAX_TESTS];

  int          num_tests;
  int          burst_beats;
  int          cycle_limit = RESET_CYCLES;
  int          cycles      = 0;
  int          errors      = 0;
  int          checks      = 0;
  logic [31:0] lfsr_state;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  axi_lite_sys DUT (
    .clk     (clk),
    .reset   (reset),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wvalid  (wvalid),
    .wready  (wready),
    .bid     (bid),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .arid    (arid),
    .araddr  (araddr),
    .arlen   (arlen),
    .arvalid (arvalid),
    .arready (arready),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  bind axi_lite_sys axi_lite_sys_properties u_properties (.*);

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per ready bit, so stalls come and go at random
  function automatic logic random_ready_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  task automatic check_b(input logic [ID_WIDTH-1:0] got_id, input resp_t got_resp,
                         input logic [ID_WIDTH-1:0] exp_id, input resp_t exp_resp);
    checks++;
    if (got_id !== exp_id) begin
      $display("MISMATCH %0t: bid %h, expected %h", $time, got_id, exp_id);
      errors++;
    end
    if (got_resp !== exp_resp) begin
      $display("MISMATCH %0t: bresp %s, expected %s", $time, got_resp.name(), exp_resp.name());
      errors++;
    end
  endtask

  task automatic check_r(input logic [ID_WIDTH-1:0] got_id, input logic [DATA_WIDTH-1:0] got_data,
                         input resp_t got_resp, input logic got_last,
                         input logic [ID_WIDTH-1:0] exp_id, input logic [DATA_WIDTH-1:0] exp_data,
                         input resp_t exp_resp, input logic exp_last, input int beat);
    checks++;
    if (got_id !== exp_id) begin
      $display("MISMATCH %0t: beat %0d rid %h, expected %h", $time, beat, got_id, exp_id);
      errors++;
    end
    if (got_data !== exp_data) begin
      $display("MISMATCH %0t: beat %0d rdata %h, expected %h", $time, beat, got_data, exp_data);
      errors++;
    end
    if (got_resp !== exp_resp) begin
      $display("MISMATCH %0t: beat %0d rresp %s, expected %s", $time, beat, got_resp.name(),
               exp_resp.name());
      errors++;
    end
    if (got_last !== exp_last) begin
      $display("MISMATCH %0t: beat %0d rlast %b, expected %b", $time, beat, got_last, exp_last);
      errors++;
    end
  endtask

  // Lines starting with # are column notes, every other line is one test
  task automatic load_vectors(output logic ok);
    int          fd;
    int          count;
    string       line;
    logic [7:0]  op;
    logic [31:0] id;
    logic [31:0] addr;
    logic [31:0] len;
    logic [31:0] data;
    logic [31:0] strb;
    logic [31:0] exp_data;
    logic [31:0] exp_resp;
    ok          = 1'b0;
    num_tests   = 0;
    burst_beats = 0;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#" && num_tests < MAX_TESTS) begin
          count = $sscanf(line, "%c %h %h %h %h %h %h %h", op, id, addr, len, data, strb,
                          exp_data, exp_resp);
          if (count == 8) begin
            vec_op[num_tests]   = op;
            vec_id[num_tests]   = id[ID_WIDTH-1:0];
            vec_addr[num_tests] = addr;
            vec_len[num_tests]  = len[LEN_WIDTH-1:0];
            vec_data[num_tests] = data;
            vec_strb[num_tests] = strb[STRB_WIDTH-1:0];
            vec_exp[num_tests]  = exp_data;
            vec_resp[num_tests] = resp_t'(exp_resp[1:0]);
            if (len != 0) burst_beats += len + 1;
            num_tests++;
          end
        end
      end
      $fclose(fd);
      ok = (num_tests > 0);
    end
    // Reset, a fixed budget per test and extra room for every burst beat
    cycle_limit = RESET_CYCLES + CYCLES_PER_TEST * num_tests + CYCLES_PER_BEAT * burst_beats;
  endtask

  // Entered and left a short delay after a rising edge
  task automatic run_write(input int t);
    int   beat;
    logic done;
    awid    = vec_id[t];
    awaddr  = vec_addr[t];
    awlen   = vec_len[t];
    awvalid = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    @(posedge clk);
    #DRIVE_DELAY;
    awvalid = 1'b0;
    // Burst beats get distinct data so a wrongly forwarded beat would show
    for (beat = 0; beat <= vec_len[t]; beat++) begin
      wdata  = vec_data[t] + beat;
      wstrb  = vec_strb[t];
      wlast  = (beat == vec_len[t]);
      wvalid = 1'b1;
      @(negedge clk);
      while (!wready) @(negedge clk);
      @(posedge clk);
      #DRIVE_DELAY;
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    done   = 1'b0;
    while (!done) begin
      bready = random_ready_bit();
      @(negedge clk);
      if (bvalid && bready) begin
        check_b(bid, bresp, vec_id[t], vec_resp[t]);
        done = 1'b1;
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    bready = 1'b0;
  endtask

  // A burst read expects length plus one beats, rlast on the final one only
  task automatic run_read(input int t);
    int beat;
    arid    = vec_id[t];
    araddr  = vec_addr[t];
    arlen   = vec_len[t];
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #DRIVE_DELAY;
    arvalid = 1'b0;
    beat    = 0;
    while (beat <= vec_len[t]) begin
      rready = random_ready_bit();
      @(negedge clk);
      if (rvalid && rready) begin
        check_r(rid, rdata, rresp, rlast, vec_id[t], vec_exp[t], vec_resp[t],
                (beat == vec_len[t]), beat);
        beat++;
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    rready = 1'b0;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, a transaction never completed", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int   errors_before;
    logic loaded;
    awid       = '0;
    awaddr     = '0;
    awlen      = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wlast      = 1'b0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    arid       = '0;
    araddr     = '0;
    arlen      = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    lfsr_state = 32'hc04c2eed;
    load_vectors(loaded);
    if (!loaded) begin
      $display("Vector file %s is missing or holds no tests", VECTOR_FILE);
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      wait (reset === 1'b0);
      @(posedge clk);
      #DRIVE_DELAY;
      // Tests run one after another, so each direction completes in issue order
      for (int t = 0; t < num_tests; t++) begin
        errors_before = errors;
        if (vec_op[t] == "W") run_write(t);
        else run_read(t);
        $display("test %0d %c id=%h addr=%h len=%0d %s", t, vec_op[t], vec_id[t],
                 vec_addr[t], vec_len[t], (errors == errors_before) ? "ok" : "failed");
      end
      $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
      if (errors == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

// File: tests/tb_clock_gen.sv
// ##############################
// Testbench clock and reset
// ##############################

module tb_clock_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  // Half of the 40 ns period
  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset drops on the edge that ends the sixteenth cycle
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule
